//--- ffcp_rx.f
logic/eth_pkg.sv
logic/ffcp_pkg.sv
logic/ethertype_filter.sv
logic/ffcp_header_parser.sv
logic/fragment_writer.sv
logic/packet_buffer_ram.sv
logic/ffcp_rx_top.sv
testbench/ffcp_rx_chk.sv
testbench/ffcp_rx_tb.sv

//--- Bender.yml
package:
  name: ffcp_rx

sources:
  # Packages first, the RTL depends on them
  - logic/eth_pkg.sv
  - logic/ffcp_pkg.sv
  - logic/ethertype_filter.sv
  - logic/ffcp_header_parser.sv
  - logic/fragment_writer.sv
  - logic/packet_buffer_ram.sv
  - logic/ffcp_rx_top.sv

  - target: simulation
    files:
      - testbench/ffcp_rx_chk.sv
      - testbench/ffcp_rx_tb.sv

//--- testbench/ffcp_rx_tb.sv
`timescale 1ns/1ps

module ffcp_rx_tb;
	import eth_pkg::*;
	import ffcp_pkg::*;

	localparam int FGP_LEN = 16;
	localparam int SLOT_COUNT = 16;
	localparam int ADDR_W = $clog2(SLOT_COUNT * FGP_LEN);
	localparam int LEN_W = $clog2(FGP_LEN) + 1;
	localparam int IDLE_GAP = 6;
	// Longest frame is 2*FGP_LEN bytes plus header, ethertype and drain
	localparam int FRAME_CYCLES = 2 * FGP_LEN + FFCP_HEADER_LEN + 16;
	localparam int READ_CYCLES = FGP_LEN + 8;
	// Seven frames and five slot reads, with a factor of two margin
	localparam int MAX_CYCLES = 2 * (7 * FRAME_CYCLES + 5 * READ_CYCLES + 8);

	logic clk = 1'b0;
	logic eth_rx_downstream_rst;
	logic ethertype_valid;
	ethertype_t ethertype;
	logic byte_valid;
	byte_t byte_data;
	logic frame_done;
	logic commit_valid;
	ffcp_index_t commit_index;
	logic commit_syn;
	logic [LEN_W-1:0] commit_len;
	logic ack_valid;
	ffcp_index_t ack_index;
	logic rd_en;
	logic [ADDR_W-1:0] rd_addr;
	logic rd_valid;
	byte_t rd_data;

	byte_t model_mem [SLOT_COUNT * FGP_LEN];
	byte_t frame_buf [64];
	logic [31:0] commit_q [$];
	ffcp_index_t ack_q [$];
	logic [ADDR_W-1:0] rd_q [$];
	logic [31:0] lcg_state = 32'h9da0_1144;
	int cycle_count = 0;

	ffcp_rx_top dut (.*);

	always #20 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Expected buffer contents and events for one frame
	function automatic void predict_frame(input ethertype_t et, input ffcp_type_t ftype,
		input ffcp_index_t idx, input int len);
		int base;
		int stored;
		logic is_syn;
		if (et != ETHERTYPE_FFCP) begin
			return;
		end
		if (ftype == FFCP_TYPE_ACK) begin
			ack_q.push_back(idx);
			return;
		end
		if (ftype != FFCP_TYPE_SYN && ftype != FFCP_TYPE_MSG) begin
			return;
		end
		is_syn = ftype == FFCP_TYPE_SYN;
		stored = (len > FGP_LEN) ? FGP_LEN : len;
		base = (idx % SLOT_COUNT) * FGP_LEN;
		for (int i = 0; i < stored; i++) begin
			model_mem[base + i] = frame_buf[i];
		end
		commit_q.push_back({8'h00, idx, 7'h00, is_syn, 8'(stored)});
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped after a failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("** Error at %0t: %s expected 0x%0h got 0x%0h",
				$time, name, expected, actual));
		end
	endtask

	task automatic fill_payload(input int len);
		for (int i = 0; i < len; i++) begin
			lcg_state = lcg_next(lcg_state);
			frame_buf[i] = lcg_state[23:16];
		end
	endtask

	// Ethertype, then header and payload bytes back to back
	task automatic drive_frame_body(input ethertype_t et, input ffcp_type_t ftype,
		input ffcp_index_t idx, input int len);
		@(negedge clk);
		ethertype_valid = 1'b1;
		ethertype = et;
		@(negedge clk);
		ethertype_valid = 1'b0;
		byte_valid = 1'b1;
		byte_data = ftype;
		@(negedge clk);
		byte_data = idx;
		for (int i = 0; i < len; i++) begin
			@(negedge clk);
			byte_data = frame_buf[i];
		end
		@(negedge clk);
		byte_valid = 1'b0;
	endtask

	task automatic send_frame(input ethertype_t et, input ffcp_type_t ftype,
		input ffcp_index_t idx, input int len);
		predict_frame(et, ftype, idx, len);
		drive_frame_body(et, ftype, idx, len);
		@(negedge clk);
		frame_done = 1'b1;
		@(negedge clk);
		frame_done = 1'b0;
	endtask

	// The end of the cut frame still arrives after reset
	task automatic abort_frame_with_reset(input ffcp_index_t idx, input int len);
		drive_frame_body(ETHERTYPE_FFCP, FFCP_TYPE_MSG, idx, len);
		eth_rx_downstream_rst = 1'b1;
		repeat (4) @(negedge clk);
		eth_rx_downstream_rst = 1'b0;
		@(negedge clk);
		frame_done = 1'b1;
		@(negedge clk);
		frame_done = 1'b0;
	endtask

	task automatic wait_for_outputs(input int limit);
		int waited;
		waited = 0;
		while ((commit_q.size() != 0 || ack_q.size() != 0 || rd_q.size() != 0)
			&& waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (commit_q.size() != 0) begin
			abort_run("An expected commit never appeared");
		end else if (ack_q.size() != 0) begin
			abort_run("An expected ACK report never appeared");
		end else if (rd_q.size() != 0) begin
			abort_run("Read data for a requested address never appeared");
		end else begin
			repeat (IDLE_GAP) @(negedge clk);
		end
	endtask

	task automatic read_slot(input int slot);
		logic [ADDR_W-1:0] addr;
		for (int i = 0; i < FGP_LEN; i++) begin
			@(negedge clk);
			addr = ADDR_W'(slot * FGP_LEN + i);
			rd_en = 1'b1;
			rd_addr = addr;
			rd_q.push_back(addr);
		end
		@(negedge clk);
		rd_en = 1'b0;
		wait_for_outputs(READ_CYCLES);
	endtask

	// Outputs change on the rising edge and are compared on the falling edge
	always @(negedge clk) begin
		logic [31:0] exp_commit;
		logic [ADDR_W-1:0] addr;
		if (dut.u_chk.assertion_failures != 0) begin
			abort_run("A protocol assertion on the DUT failed");
		end
		if (commit_valid === 1'b1) begin
			if (commit_q.size() == 0) begin
				abort_run("A commit appeared that no frame should have produced");
			end else begin
				exp_commit = commit_q.pop_front();
				check_value("commit_index", exp_commit[23:16], commit_index);
				check_value("commit_syn", exp_commit[8], commit_syn);
				check_value("commit_len", exp_commit[7:0], commit_len);
			end
		end
		if (ack_valid === 1'b1) begin
			if (ack_q.size() == 0) begin
				abort_run("An ACK report appeared that no frame should have produced");
			end else begin
				check_value("ack_index", ack_q.pop_front(), ack_index);
			end
		end
		if (rd_valid === 1'b1) begin
			if (rd_q.size() == 0) begin
				abort_run("Read data appeared without a pending read");
			end else begin
				addr = rd_q.pop_front();
				check_value("rd_data", model_mem[addr], rd_data);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			abort_run("Timeout, the tests did not finish within the cycle limit");
		end
	end

	initial begin
		eth_rx_downstream_rst = 1'b1;
		ethertype_valid = 1'b0;
		ethertype = '0;
		byte_valid = 1'b0;
		byte_data = '0;
		frame_done = 1'b0;
		rd_en = 1'b0;
		rd_addr = '0;
		repeat (4) @(negedge clk);
		eth_rx_downstream_rst = 1'b0;

		// Full MSG fragment into slot 3
		fill_payload(FGP_LEN);
		send_frame(ETHERTYPE_FFCP, FFCP_TYPE_MSG, 8'h23, FGP_LEN);
		wait_for_outputs(FRAME_CYCLES);
		read_slot(3);

		// Oversized SYN, only the first FGP_LEN bytes land in slot 5
		fill_payload(FGP_LEN + 8);
		send_frame(ETHERTYPE_FFCP, FFCP_TYPE_SYN, 8'h45, FGP_LEN + 8);
		wait_for_outputs(FRAME_CYCLES);
		read_slot(5);

		// Foreign ethertype aimed at slot 3 must leave it alone
		fill_payload(FGP_LEN);
		send_frame(16'h0800, FFCP_TYPE_MSG, 8'h13, FGP_LEN);
		wait_for_outputs(FRAME_CYCLES);
		read_slot(3);

		send_frame(ETHERTYPE_FFCP, FFCP_TYPE_ACK, 8'h77, 0);
		wait_for_outputs(FRAME_CYCLES);

		// Short MSG over slot 5, tail keeps the SYN bytes
		fill_payload(5);
		send_frame(ETHERTYPE_FFCP, FFCP_TYPE_MSG, 8'h15, 5);
		wait_for_outputs(FRAME_CYCLES);
		read_slot(5);

		// Reset cuts a frame short, then a full frame to the same slot
		fill_payload(6);
		abort_frame_with_reset(8'h2a, 6);
		wait_for_outputs(FRAME_CYCLES);
		fill_payload(FGP_LEN);
		send_frame(ETHERTYPE_FFCP, FFCP_TYPE_MSG, 8'h2a, FGP_LEN);
		wait_for_outputs(FRAME_CYCLES);
		read_slot(10);

		if (dut.u_chk.assertion_failures == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			abort_run("A protocol assertion on the DUT failed");
		end
	end

endmodule

//--- testbench/ffcp_rx_chk.sv
`timescale 1ns/1ps

module ffcp_rx_chk (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input logic commit_valid,
	input logic ack_valid,
	input logic rd_en,
	input logic rd_valid
);
	import ffcp_pkg::*;

	int assertion_failures = 0;

	// Commits and ACK reports never share a cycle
	commit_ack_exclusive: assert property (
		@(posedge clk) disable iff (eth_rx_downstream_rst)
		!(commit_valid && ack_valid)
	) else begin
		$error("commit_valid and ack_valid high in the same cycle");
		assertion_failures++;
	end

	read_latency: assert property (
		@(posedge clk) disable iff (eth_rx_downstream_rst)
		rd_en |-> ##PACKET_BUFFER_READ_LATENCY rd_valid
	) else begin
		$error("rd_valid missing after rd_en");
		assertion_failures++;
	end

	// Every rd_valid belongs to an earlier rd_en
	read_valid_source: assert property (
		@(posedge clk) disable iff (eth_rx_downstream_rst)
		rd_valid |-> $past(rd_en, PACKET_BUFFER_READ_LATENCY)
	) else begin
		$error("rd_valid without a matching rd_en");
		assertion_failures++;
	end

	strobes_low_after_reset: assert property (
		@(posedge clk) $fell(eth_rx_downstream_rst) |-> !commit_valid && !ack_valid
	) else begin
		$error("commit_valid or ack_valid high right after reset");
		assertion_failures++;
	end

endmodule

bind ffcp_rx_top ffcp_rx_chk u_chk (
	.clk(clk),
	.eth_rx_downstream_rst(eth_rx_downstream_rst),
	.commit_valid(commit_valid),
	.ack_valid(ack_valid),
	.rd_en(rd_en),
	.rd_valid(rd_valid)
);

//--- logic/ffcp_rx_top.sv
`timescale 1ns/1ps

module ffcp_rx_top #(
	parameter int FGP_LEN = 16,
	parameter int SLOT_COUNT = 16
) (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input logic ethertype_valid,
	input eth_pkg::ethertype_t ethertype,
	input logic byte_valid,
	input eth_pkg::byte_t byte_data,
	input logic frame_done,
	output logic commit_valid,
	output ffcp_pkg::ffcp_index_t commit_index,
	output logic commit_syn,
	output logic [$clog2(FGP_LEN):0] commit_len,
	output logic ack_valid,
	output ffcp_pkg::ffcp_index_t ack_index,
	input logic rd_en,
	input logic [$clog2(SLOT_COUNT*FGP_LEN)-1:0] rd_addr,
	output logic rd_valid,
	output eth_pkg::byte_t rd_data
);
	import eth_pkg::*;
	import ffcp_pkg::*;

	localparam int ADDR_W = $clog2(SLOT_COUNT * FGP_LEN);

	// Filter to parser
	logic ffcp_valid;
	logic ffcp_done;
	byte_t ffcp_byte;

	// Parser to writer
	logic meta_valid;
	ffcp_type_t meta_type;
	ffcp_index_t meta_index;
	logic payload_valid;
	byte_t payload_byte;
	logic frame_end;

	// Writer to buffer
	logic wr_en;
	logic [ADDR_W-1:0] wr_addr;
	byte_t wr_data;

	ethertype_filter u_filter (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.ethertype_valid(ethertype_valid),
		.ethertype(ethertype),
		.byte_valid(byte_valid),
		.byte_data(byte_data),
		.frame_done(frame_done),
		.ffcp_valid(ffcp_valid),
		.ffcp_byte(ffcp_byte),
		.ffcp_done(ffcp_done)
	);

	ffcp_header_parser u_parser (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.ffcp_valid(ffcp_valid),
		.ffcp_byte(ffcp_byte),
		.ffcp_done(ffcp_done),
		.meta_valid(meta_valid),
		.meta_type(meta_type),
		.meta_index(meta_index),
		.payload_valid(payload_valid),
		.payload_byte(payload_byte),
		.frame_end(frame_end)
	);

	fragment_writer #(
		.FGP_LEN(FGP_LEN),
		.SLOT_COUNT(SLOT_COUNT)
	) u_writer (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.meta_valid(meta_valid),
		.meta_type(meta_type),
		.meta_index(meta_index),
		.payload_valid(payload_valid),
		.payload_byte(payload_byte),
		.frame_end(frame_end),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.commit_valid(commit_valid),
		.commit_index(commit_index),
		.commit_syn(commit_syn),
		.commit_len(commit_len),
		.ack_valid(ack_valid),
		.ack_index(ack_index)
	);

	packet_buffer_ram #(
		.FGP_LEN(FGP_LEN),
		.SLOT_COUNT(SLOT_COUNT)
	) u_buffer (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_valid(rd_valid),
		.rd_data(rd_data)
	);

endmodule

//--- logic/packet_buffer_ram.sv
`timescale 1ns/1ps

module packet_buffer_ram #(
	parameter int FGP_LEN = 16,
	parameter int SLOT_COUNT = 16
) (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input logic wr_en,
	input logic [$clog2(SLOT_COUNT*FGP_LEN)-1:0] wr_addr,
	input eth_pkg::byte_t wr_data,
	input logic rd_en,
	input logic [$clog2(SLOT_COUNT*FGP_LEN)-1:0] rd_addr,
	output logic rd_valid,
	output eth_pkg::byte_t rd_data
);
	import eth_pkg::*;
	import ffcp_pkg::*;

	localparam int DEPTH = SLOT_COUNT * FGP_LEN;
	localparam int LAT = PACKET_BUFFER_READ_LATENCY;

	byte_t mem [DEPTH];
	byte_t rd_pipe [LAT];
	logic [LAT-1:0] rd_valid_pipe;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Array read followed by output registers
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_pipe[0] <= mem[rd_addr];
		end
		for (int i = 1; i < LAT; i++) begin
			rd_pipe[i] <= rd_pipe[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			rd_valid_pipe <= '0;
		end else begin
			rd_valid_pipe[0] <= rd_en;
			for (int i = 1; i < LAT; i++) begin
				rd_valid_pipe[i] <= rd_valid_pipe[i-1];
			end
		end
	end

	assign rd_valid = rd_valid_pipe[LAT-1];
	assign rd_data = rd_pipe[LAT-1];

endmodule

//--- logic/fragment_writer.sv
`timescale 1ns/1ps

module fragment_writer #(
	parameter int FGP_LEN = 16,
	parameter int SLOT_COUNT = 16
) (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input logic meta_valid,
	input ffcp_pkg::ffcp_type_t meta_type,
	input ffcp_pkg::ffcp_index_t meta_index,
	input logic payload_valid,
	input eth_pkg::byte_t payload_byte,
	input logic frame_end,
	output logic wr_en,
	output logic [$clog2(SLOT_COUNT*FGP_LEN)-1:0] wr_addr,
	output eth_pkg::byte_t wr_data,
	output logic commit_valid,
	output ffcp_pkg::ffcp_index_t commit_index,
	output logic commit_syn,
	output logic [$clog2(FGP_LEN):0] commit_len,
	output logic ack_valid,
	output ffcp_pkg::ffcp_index_t ack_index
);
	import ffcp_pkg::*;

	localparam int SLOT_W = $clog2(SLOT_COUNT);
	localparam int OFS_W = $clog2(FGP_LEN);
	localparam int LEN_W = OFS_W + 1;

	ffcp_index_t index_buf;
	logic syn_buf;
	logic active;
	logic [LEN_W-1:0] byte_cnt;
	logic is_data;
	logic slot_full;
	logic accept;

	assign is_data = meta_type == FFCP_TYPE_SYN || meta_type == FFCP_TYPE_MSG;
	assign slot_full = byte_cnt == LEN_W'(FGP_LEN);
	// Bytes past the end of the slot are dropped
	assign accept = payload_valid && active && !slot_full;

	// Only SYN and MSG frames store payload
	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			active <= 1'b0;
			byte_cnt <= '0;
		end else if (meta_valid) begin
			active <= is_data;
			byte_cnt <= '0;
		end else if (frame_end) begin
			active <= 1'b0;
			byte_cnt <= '0;
		end else if (accept) begin
			byte_cnt <= byte_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (meta_valid && is_data) begin
			index_buf <= meta_index;
			syn_buf <= meta_type == FFCP_TYPE_SYN;
		end
	end

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			wr_en <= 1'b0;
		end else begin
			wr_en <= accept;
		end
	end

	// Low index bits select the slot, the count selects the byte in it
	always_ff @(posedge clk) begin
		wr_addr <= {index_buf[SLOT_W-1:0], byte_cnt[OFS_W-1:0]};
		wr_data <= payload_byte;
	end

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			commit_valid <= 1'b0;
			ack_valid <= 1'b0;
		end else begin
			commit_valid <= frame_end && active;
			ack_valid <= meta_valid && meta_type == FFCP_TYPE_ACK;
		end
	end

	always_ff @(posedge clk) begin
		if (frame_end) begin
			commit_index <= index_buf;
			commit_syn <= syn_buf;
			commit_len <= byte_cnt;
		end
		if (meta_valid) begin
			ack_index <= meta_index;
		end
	end

endmodule

//--- logic/ffcp_header_parser.sv
`timescale 1ns/1ps

module ffcp_header_parser (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input logic ffcp_valid,
	input eth_pkg::byte_t ffcp_byte,
	input logic ffcp_done,
	output logic meta_valid,
	output ffcp_pkg::ffcp_type_t meta_type,
	output ffcp_pkg::ffcp_index_t meta_index,
	output logic payload_valid,
	output eth_pkg::byte_t payload_byte,
	output logic frame_end
);
	import ffcp_pkg::*;

	localparam int HDR_CNT_W = $clog2(FFCP_HEADER_LEN);

	typedef enum logic [1:0] {
		ST_TYPE,
		ST_INDEX,
		ST_PAYLOAD
	} parser_state_e;

	parser_state_e state;
	logic [HDR_CNT_W-1:0] hdr_cnt;
	ffcp_type_t type_buf;
	logic index_byte;
	logic index_accept;

	// The index is the last header byte
	assign index_byte = hdr_cnt == HDR_CNT_W'(FFCP_HEADER_LEN - 1);
	assign index_accept = ffcp_valid && state == ST_INDEX && index_byte;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			state <= ST_TYPE;
			hdr_cnt <= '0;
		end else if (ffcp_done) begin
			state <= ST_TYPE;
			hdr_cnt <= '0;
		end else if (ffcp_valid) begin
			case (state)
				ST_TYPE: begin
					state <= ST_INDEX;
					hdr_cnt <= HDR_CNT_W'(1);
				end
				ST_INDEX: begin
					hdr_cnt <= hdr_cnt + 1'b1;
					if (index_byte) begin
						state <= ST_PAYLOAD;
					end
				end
				default: begin
					state <= ST_PAYLOAD;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ffcp_valid && state == ST_TYPE) begin
			type_buf <= ffcp_byte;
		end
	end

	// Frames cut short inside the header never reach ST_PAYLOAD
	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			meta_valid <= 1'b0;
			payload_valid <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			meta_valid <= index_accept;
			payload_valid <= ffcp_valid && state == ST_PAYLOAD;
			frame_end <= ffcp_done && state == ST_PAYLOAD;
		end
	end

	always_ff @(posedge clk) begin
		if (index_accept) begin
			meta_type <= type_buf;
			meta_index <= ffcp_byte;
		end
		payload_byte <= ffcp_byte;
	end

endmodule

//--- logic/ethertype_filter.sv
`timescale 1ns/1ps

module ethertype_filter (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input logic ethertype_valid,
	input eth_pkg::ethertype_t ethertype,
	input logic byte_valid,
	input eth_pkg::byte_t byte_data,
	input logic frame_done,
	output logic ffcp_valid,
	output eth_pkg::byte_t ffcp_byte,
	output logic ffcp_done
);
	import eth_pkg::*;

	logic ffcp_en;

	// Decided once per frame when the ethertype arrives
	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			ffcp_en <= 1'b0;
		end else if (ethertype_valid) begin
			ffcp_en <= ethertype == ETHERTYPE_FFCP;
		end else if (frame_done) begin
			ffcp_en <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			ffcp_valid <= 1'b0;
			ffcp_done <= 1'b0;
		end else begin
			ffcp_valid <= byte_valid && ffcp_en;
			ffcp_done <= frame_done && ffcp_en;
		end
	end

	always_ff @(posedge clk) begin
		ffcp_byte <= byte_data;
	end

endmodule

//--- logic/ffcp_pkg.sv
package ffcp_pkg;

	// Packet type code, first byte of the FFCP header
	typedef logic [7:0] ffcp_type_t;

	// Sequence index, last byte of the FFCP header
	typedef logic [7:0] ffcp_index_t;

	// Type codes
	localparam ffcp_type_t FFCP_TYPE_SYN = 8'd1;
	localparam ffcp_type_t FFCP_TYPE_MSG = 8'd2;
	localparam ffcp_type_t FFCP_TYPE_ACK = 8'd3;

	// Header bytes ahead of the payload
	localparam int FFCP_HEADER_LEN = 2;

	// Cycles from rd_en to rd_valid on the packet buffer
	localparam int PACKET_BUFFER_READ_LATENCY = 2;

endpackage

//--- logic/eth_pkg.sv
package eth_pkg;

	// One octet of received frame data
	typedef logic [7:0] byte_t;

	// Ethertype field as delivered by the frame receiver
	typedef logic [15:0] ethertype_t;

	// Frames carrying this ethertype are FFCP traffic
	localparam ethertype_t ETHERTYPE_FFCP = 16'h1a1a;

endpackage
